// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_pdp8
FILELIST  := pdp8.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard design/*.sv design/*.svh verification/*.sv)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "Run reported failure"; exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "No pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/pdp8_cfg.svh ====
// Word, address and memory sizes, opcode values, auto-increment range, instruction field bits
`ifndef PDP8_CFG_SVH
`define PDP8_CFG_SVH

// Sizes
`define PDP8_WORD_W     12
`define PDP8_ADDR_W     12
`define PDP8_MEM_DEPTH  4096
`define PDP8_PAGE_W     5       // Upper address bits select one of 32 pages
`define PDP8_OFFSET_W   7       // 128 words per page

// Opcodes in IR[11:9]
`define PDP8_OP_AND     3'o0
`define PDP8_OP_TAD     3'o1
`define PDP8_OP_ISZ     3'o2
`define PDP8_OP_DCA     3'o3
`define PDP8_OP_JMS     3'o4
`define PDP8_OP_JMP     3'o5
`define PDP8_OP_IOT     3'o6    // Treated as no-op
`define PDP8_OP_OPR     3'o7

// Zero-page pointers that bump on indirect use
`define PDP8_AUTOINC_LO 12'o0010
`define PDP8_AUTOINC_HI 12'o0017

// Memory reference fields
`define PDP8_IR_IND_BIT  8
`define PDP8_IR_PAGE_BIT 7

// Operate group select
`define PDP8_OPR_GRP_BIT 8      // Clear selects group 1
`define PDP8_OPR_G3_BIT  0      // With GRP set, high selects group 3

`endif

// ==== design/pdp8_control.sv ====
// Instruction sequencer with PC, IR, effective address, FSM and memory requests
`timescale 1ns/1ps
`include "pdp8_cfg.svh"

module pdp8_control (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_start,
	input  pdp8_pkg::addr_t    i_start_pc,
	input  pdp8_pkg::word_t    i_mem_rdata,
	input  pdp8_pkg::word_t    i_ac,
	input  logic               i_skip,
	input  logic               i_halt,
	output pdp8_pkg::mem_req_t o_mem_req,
	output pdp8_pkg::dp_cmd_t  o_dp_cmd,
	output logic               o_running,
	output pdp8_pkg::addr_t    o_pc
);
	import pdp8_pkg::*;

	cpu_state_e state;
	cpu_state_e state_nx;
	addr_t      pc;
	addr_t      pc_nx;
	word_t      ir;
	addr_t      ea;         // Effective address, holds pointer address in DEFER

	opcode_t    dec_op;     // Opcode of the word arriving in DECODE
	opcode_t    ir_op;
	page_t      pc_page;
	offset_t    dec_off;
	offset_t    ir_off;
	addr_t      dir_addr;   // Zero page or current page address
	logic       autoinc;
	word_t      opnd_inc;   // ISZ result
	logic       isz_hit;

	// AND, TAD and ISZ need the operand word
	function automatic logic reads_operand(input opcode_t op);
		return (op == `PDP8_OP_AND) || (op == `PDP8_OP_TAD) || (op == `PDP8_OP_ISZ);
	endfunction

	// ===================================================================
	// Address forming
	// ===================================================================
	assign dec_op   = i_mem_rdata[11:9];
	assign dec_off  = i_mem_rdata[6:0];
	assign ir_op    = ir[11:9];
	assign ir_off   = ir[6:0];
	assign pc_page  = pc[11:7];
	assign dir_addr = i_mem_rdata[`PDP8_IR_PAGE_BIT] ? {pc_page, dec_off}
	                                                 : {page_t'(0), dec_off};

	// Indirect through 0010-0017 with page bit clear bumps the pointer
	assign autoinc  = !ir[`PDP8_IR_PAGE_BIT] &&
	                  (ea >= `PDP8_AUTOINC_LO) && (ea <= `PDP8_AUTOINC_HI);

	assign opnd_inc = i_mem_rdata + word_t'(1);    // Operand read in OPERAND
	assign isz_hit  = (ir_op == `PDP8_OP_ISZ) && (opnd_inc == '0);

	// ===================================================================
	// Next state and memory requests
	// ===================================================================
	always_comb begin
		state_nx  = state;
		o_mem_req = '0;
		case (state)
			IDLE: begin
				if (i_start)
					state_nx = FETCH;
			end
			FETCH: begin
				o_mem_req.rd   = 1'b1;
				o_mem_req.addr = pc;
				state_nx       = DECODE;
			end
			DECODE: begin
				if (dec_op == `PDP8_OP_OPR || dec_op == `PDP8_OP_IOT) begin
					state_nx = EXECUTE;                 // No address phase
				end else if (i_mem_rdata[`PDP8_IR_IND_BIT]) begin
					o_mem_req.rd   = 1'b1;              // Fetch pointer
					o_mem_req.addr = dir_addr;
					state_nx       = DEFER;
				end else if (reads_operand(dec_op)) begin
					state_nx = OPERAND;
				end else begin
					state_nx = EXECUTE;
				end
			end
			DEFER: begin
				if (autoinc)
					state_nx = AUTOINC;
				else if (reads_operand(ir_op))
					state_nx = OPERAND;
				else
					state_nx = EXECUTE;
			end
			AUTOINC: begin
				o_mem_req.wr    = 1'b1;                 // ea already holds pointer + 1
				o_mem_req.addr  = {page_t'(0), ir_off};
				o_mem_req.wdata = ea;
				state_nx        = reads_operand(ir_op) ? OPERAND : EXECUTE;
			end
			OPERAND: begin
				o_mem_req.rd   = 1'b1;
				o_mem_req.addr = ea;
				state_nx       = EXECUTE;
			end
			EXECUTE: begin
				o_mem_req.addr = ea;
				case (ir_op)
					`PDP8_OP_ISZ: begin
						o_mem_req.wr    = 1'b1;
						o_mem_req.wdata = opnd_inc;
					end
					`PDP8_OP_DCA: begin
						o_mem_req.wr    = 1'b1;
						o_mem_req.wdata = i_ac;
					end
					`PDP8_OP_JMS: begin
						o_mem_req.wr    = 1'b1;         // Return address
						o_mem_req.wdata = pc + addr_t'(1);
					end
					default: ;
				endcase
				state_nx = (ir_op == `PDP8_OP_OPR && i_halt) ? IDLE : FETCH;
			end
			default: state_nx = IDLE;
		endcase
	end

	// Datapath command, only live in EXECUTE
	always_comb begin
		o_dp_cmd.instr   = ir;
		o_dp_cmd.operand = i_mem_rdata;
		o_dp_cmd.op      = NONE;
		if (state == EXECUTE) begin
			case (ir_op)
				`PDP8_OP_AND: o_dp_cmd.op = AND;
				`PDP8_OP_TAD: o_dp_cmd.op = TAD;
				`PDP8_OP_DCA: o_dp_cmd.op = CLEAR_AC;
				`PDP8_OP_OPR: o_dp_cmd.op = OPERATE;
				default:      o_dp_cmd.op = NONE;
			endcase
		end
	end

	// PC rule from the ISA
	always_comb begin
		if (ir_op == `PDP8_OP_JMS)
			pc_nx = ea + addr_t'(1);
		else if (ir_op == `PDP8_OP_JMP)
			pc_nx = ea;
		else if (isz_hit || i_skip)
			pc_nx = pc + addr_t'(2);
		else
			pc_nx = pc + addr_t'(1);
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= IDLE;
			pc    <= '0;
			ir    <= '0;
			ea    <= '0;
		end else begin
			state <= state_nx;
			case (state)
				IDLE: begin
					if (i_start)
						pc <= i_start_pc;
				end
				DECODE: begin
					ir <= i_mem_rdata;
					ea <= dir_addr;
				end
				DEFER:   ea <= autoinc ? i_mem_rdata + word_t'(1) : i_mem_rdata;
				EXECUTE: pc <= pc_nx;
				default: ;
			endcase
		end
	end

	assign o_running = (state != IDLE);     // Falls the cycle after HLT
	assign o_pc      = pc;

	a_state_legal: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		state inside {IDLE, FETCH, DECODE, DEFER, AUTOINC, OPERAND, EXECUTE}
	) else $error("Sequencer reached an undefined state");

	a_no_fetch_write: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		(state == FETCH) |-> !o_mem_req.wr
	) else $error("Memory write issued during FETCH");

endmodule

// ==== design/pdp8_datapath.sv ====
// Accumulator, link and MQ registers with AND, TAD, DCA and operate updates
`timescale 1ns/1ps

module pdp8_datapath (
	input  logic              i_clk,
	input  logic              i_rst_n,
	input  pdp8_pkg::dp_cmd_t i_cmd,
	input  pdp8_pkg::word_t   i_switch,
	output pdp8_pkg::word_t   o_ac,
	output logic              o_link,
	output pdp8_pkg::word_t   o_mq,
	output logic              o_skip,
	output logic              o_halt
);
	import pdp8_pkg::*;

	word_t ac;
	logic  link;
	word_t mq;

	// Operate results
	word_t opr_ac;
	logic  opr_link;
	word_t opr_mq;
	logic  opr_skip;
	logic  opr_halt;
	logic  is_opr;

	pdp8_operate operate_i (
		.i_instr  (i_cmd.instr),
		.i_ac     (ac),
		.i_link   (link),
		.i_mq     (mq),
		.i_switch (i_switch),
		.o_ac     (opr_ac),
		.o_link   (opr_link),
		.o_mq     (opr_mq),
		.o_skip   (opr_skip),
		.o_halt   (opr_halt)
	);

	assign is_opr = (i_cmd.op == OPERATE);
	assign o_skip = is_opr & opr_skip;     // Seen by sequencer in EXECUTE
	assign o_halt = is_opr & opr_halt;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			ac   <= '0;
			link <= 1'b0;
			mq   <= '0;
		end else begin
			case (i_cmd.op)
				AND:      ac <= ac & i_cmd.operand;
				// 13 bit add, carry out flips the link
				TAD:      {link, ac} <= {link, ac} + {1'b0, i_cmd.operand};
				CLEAR_AC: ac <= '0;                 // Store already done by DCA
				OPERATE: begin
					ac   <= opr_ac;
					link <= opr_link;
					mq   <= opr_mq;
				end
				default: ;
			endcase
		end
	end

	assign o_ac   = ac;
	assign o_link = link;
	assign o_mq   = mq;

endmodule

// ==== design/pdp8_memory.sv ====
// Core memory with processor port, load write port and registered peek port
`timescale 1ns/1ps
`include "pdp8_cfg.svh"

module pdp8_memory (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  pdp8_pkg::mem_req_t i_req,
	output pdp8_pkg::word_t    o_rdata,
	input  logic               i_load_we,
	input  pdp8_pkg::addr_t    i_load_addr,
	input  pdp8_pkg::word_t    i_load_data,
	input  pdp8_pkg::addr_t    i_peek_addr,
	output pdp8_pkg::word_t    o_peek_data
);
	import pdp8_pkg::*;

	word_t mem [`PDP8_MEM_DEPTH];    // 4K x 12 core

	logic  wr_en;
	addr_t wr_addr;
	word_t wr_data;

	// One write path, load port takes it when active
	always_comb begin
		wr_en   = i_load_we | i_req.wr;
		wr_addr = i_load_we ? i_load_addr : i_req.addr;
		wr_data = i_load_we ? i_load_data : i_req.wdata;
	end

	always_ff @(posedge i_clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Registered reads, data valid the cycle after the request
	always_ff @(posedge i_clk) begin
		if (i_req.rd)
			o_rdata <= mem[i_req.addr];    // Holds last read otherwise
		o_peek_data <= mem[i_peek_addr];   // Peek is free running
	end

	// Loads belong to the idle CPU, so they never meet a processor store
	a_load_vs_cpu_write: assert property (
		@(posedge i_clk) disable iff (!i_rst_n)
		!(i_load_we && i_req.wr)
	) else $error("Load port write collided with processor write at %o", i_req.addr);

endmodule

// ==== design/pdp8_operate.sv ====
// Combinational operate decode for groups 1, 2 and 3 with skip and halt
`timescale 1ns/1ps
`include "pdp8_cfg.svh"

module pdp8_operate (
	input  pdp8_pkg::word_t i_instr,
	input  pdp8_pkg::word_t i_ac,
	input  logic            i_link,
	input  pdp8_pkg::word_t i_mq,
	input  pdp8_pkg::word_t i_switch,
	output pdp8_pkg::word_t o_ac,
	output logic            o_link,
	output pdp8_pkg::word_t o_mq,
	output logic            o_skip,
	output logic            o_halt
);
	import pdp8_pkg::*;

	logic                 cla;       // Bit 4 in every group
	word_t                cla_ac;    // AC after CLA
	logic [`PDP8_WORD_W:0] rot;      // Link above AC

	word_t g1_ac;
	logic  g1_link;

	logic  ac_neg;
	logic  ac_zero;
	logic  or_hit;
	logic  g2_skip;
	word_t g2_ac;

	word_t g3_ac;
	word_t g3_mq;

	assign cla    = i_instr[7];
	assign cla_ac = cla ? '0 : i_ac;

	// ===================================================================
	// Group 1  CLA CLL, CMA CML, IAC, then rotates
	// ===================================================================
	always_comb begin
		g1_ac   = cla_ac;
		g1_link = i_instr[6] ? 1'b0 : i_link;      // CLL
		if (i_instr[5])
			g1_ac = ~g1_ac;                         // CMA
		if (i_instr[4])
			g1_link = ~g1_link;                     // CML
		if (i_instr[0])
			{g1_link, g1_ac} = {g1_link, g1_ac} + 13'd1;   // IAC carries into link
		rot = {g1_link, g1_ac};
		if (i_instr[3]) begin                       // RAR, RTR with bit 1
			rot = {rot[0], rot[`PDP8_WORD_W:1]};
			if (i_instr[1])
				rot = {rot[0], rot[`PDP8_WORD_W:1]};
		end
		if (i_instr[2]) begin                       // RAL, RTL with bit 1
			rot = {rot[`PDP8_WORD_W-1:0], rot[`PDP8_WORD_W]};
			if (i_instr[1])
				rot = {rot[`PDP8_WORD_W-1:0], rot[`PDP8_WORD_W]};
		end
		{g1_link, g1_ac} = rot;
	end

	// ===================================================================
	// Group 2  skip test on old AC and link, then CLA, OSR, HLT
	// ===================================================================
	assign ac_neg  = i_ac[`PDP8_WORD_W-1];
	assign ac_zero = (i_ac == '0);
	assign or_hit  = (i_instr[6] & ac_neg) |       // SMA or SPA
	                 (i_instr[5] & ac_zero) |      // SZA or SNA
	                 (i_instr[4] & i_link);        // SNL or SZL
	assign g2_skip = i_instr[3] ? ~or_hit : or_hit; // Sense bit picks AND group, SKP when empty
	assign g2_ac   = cla_ac | (i_instr[2] ? i_switch : '0);

	// Group 3  MQA bit 6, MQL bit 4
	assign g3_ac = (i_instr[6] ? i_mq : '0) | (i_instr[4] ? '0 : cla_ac);
	assign g3_mq = i_instr[4] ? cla_ac : i_mq;

	always_comb begin
		o_ac   = i_ac;
		o_link = i_link;
		o_mq   = i_mq;
		o_skip = 1'b0;
		o_halt = 1'b0;
		if (!i_instr[`PDP8_OPR_GRP_BIT]) begin
			o_ac   = g1_ac;
			o_link = g1_link;
		end else if (i_instr[`PDP8_OPR_G3_BIT]) begin
			o_ac = g3_ac;                           // SWP and CAM fall out of this
			o_mq = g3_mq;
		end else begin
			o_ac   = g2_ac;
			o_skip = g2_skip;
			o_halt = i_instr[1];
		end
	end

endmodule

// ==== design/pdp8_pkg.sv ====
// Word and address typedefs, FSM and datapath enums, memory request and datapath command structs
`include "pdp8_cfg.svh"

package pdp8_pkg;

	// ===================================================================
	// Plain vector types
	// ===================================================================
	typedef logic [`PDP8_WORD_W-1:0]   word_t;     // Bit 11 is MSB and sign
	typedef logic [`PDP8_ADDR_W-1:0]   addr_t;
	typedef logic [`PDP8_PAGE_W-1:0]   page_t;
	typedef logic [`PDP8_OFFSET_W-1:0] offset_t;
	typedef logic [2:0]                opcode_t;   // IR[11:9]

	// ===================================================================
	// State machine and datapath command
	// ===================================================================
	typedef enum logic [2:0] {
		IDLE,       // Waiting for start pulse
		FETCH,      // Read at PC
		DECODE,     // Instruction word arrives
		DEFER,      // Pointer word arrives
		AUTOINC,    // Write back bumped pointer
		OPERAND,    // Read at effective address
		EXECUTE     // Datapath update, stores, PC update
	} cpu_state_e;

	typedef enum logic [2:0] {
		NONE,
		AND,        // AC &= operand
		TAD,        // L,AC += operand
		CLEAR_AC,   // DCA clears AC after the store
		OPERATE     // Load operate group results
	} exec_op_e;

	// Processor side memory request
	typedef struct packed {
		logic  rd;
		logic  wr;
		addr_t addr;
		word_t wdata;
	} mem_req_t;

	// Command from sequencer to datapath
	typedef struct packed {
		exec_op_e op;
		word_t    instr;
		word_t    operand;
	} dp_cmd_t;

endpackage

// ==== design/pdp8_top.sv ====
// CPU top with sequencer, datapath and memory instances
`timescale 1ns/1ps

module pdp8_top (
	input  logic            i_clk,
	input  logic            i_rst_n,
	input  logic            i_start,
	input  pdp8_pkg::addr_t i_start_pc,
	input  pdp8_pkg::word_t i_switch,
	input  logic            i_load_we,
	input  pdp8_pkg::addr_t i_load_addr,
	input  pdp8_pkg::word_t i_load_data,
	input  pdp8_pkg::addr_t i_peek_addr,
	output pdp8_pkg::word_t o_peek_data,
	output logic            o_running,
	output pdp8_pkg::addr_t o_pc,
	output pdp8_pkg::word_t o_ac,
	output logic            o_link,
	output pdp8_pkg::word_t o_mq
);
	import pdp8_pkg::*;

	mem_req_t mem_req;
	word_t    mem_rdata;
	dp_cmd_t  dp_cmd;
	logic     skip;
	logic     halt;

	pdp8_control control_i (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.i_start_pc  (i_start_pc),
		.i_mem_rdata (mem_rdata),
		.i_ac        (o_ac),
		.i_skip      (skip),
		.i_halt      (halt),
		.o_mem_req   (mem_req),
		.o_dp_cmd    (dp_cmd),
		.o_running   (o_running),
		.o_pc        (o_pc)
	);

	pdp8_datapath datapath_i (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_cmd    (dp_cmd),
		.i_switch (i_switch),
		.o_ac     (o_ac),
		.o_link   (o_link),
		.o_mq     (o_mq),
		.o_skip   (skip),
		.o_halt   (halt)
	);

	pdp8_memory memory_i (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_req       (mem_req),
		.o_rdata     (mem_rdata),
		.i_load_we   (i_load_we),
		.i_load_addr (i_load_addr),
		.i_load_data (i_load_data),
		.i_peek_addr (i_peek_addr),
		.o_peek_data (o_peek_data)
	);

endmodule

// ==== pdp8.f ====
+incdir+design
design/pdp8_pkg.sv
design/pdp8_memory.sv
design/pdp8_operate.sv
design/pdp8_datapath.sv
design/pdp8_control.sv
design/pdp8_top.sv
verification/tb_pdp8.sv

// ==== verification/tb_pdp8.sv ====
// Testbench for the PDP-8 CPU with clock, reset, program loading, six tests and a summary
`timescale 1ns/1ps

module tb_pdp8;
	import pdp8_pkg::*;

	localparam int RUN_LIMIT = 4000;    // Cycles allowed for one program
	localparam int MAX_WORDS = 16;

	typedef logic [MAX_WORDS*12-1:0] block_t;   // First program word is leftmost

	logic  clk;
	logic  rst_n;
	logic  start;
	addr_t start_pc;
	word_t switches;
	logic  load_we;
	addr_t load_addr;
	word_t load_data;
	addr_t peek_addr;
	word_t peek_data;
	logic  running;
	addr_t pc;
	word_t ac;
	logic  link;
	word_t mq;

	int errors;
	int errors_before;      // Error count when the current test began
	int tests_run;
	int tests_failed;

	pdp8_top dut_i (
		.i_clk       (clk),
		.i_rst_n     (rst_n),
		.i_start     (start),
		.i_start_pc  (start_pc),
		.i_switch    (switches),
		.i_load_we   (load_we),
		.i_load_addr (load_addr),
		.i_load_data (load_data),
		.i_peek_addr (peek_addr),
		.o_peek_data (peek_data),
		.o_running   (running),
		.o_pc        (pc),
		.o_ac        (ac),
		.o_link      (link),
		.o_mq        (mq)
	);

	always #4 clk = ~clk;      // 8 ns period

	// ======================================================================
	// Checks and reference helpers
	// ======================================================================
	task automatic compare_word(input string what, input word_t got, input word_t exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s is %o, expected %o", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	// Rotate link and AC left by n places or right for negative n
	function automatic logic [12:0] rotate13(input logic [12:0] v, input int n);
		logic [12:0] r;
		for (int i = 0; i < 13; i++)
			r[(i + n + 13) % 13] = v[i];
		return r;
	endfunction

	// Group 2 skip word for case k
	function automatic word_t skip_op(input int k);
		case (k)
			0:       return 12'o7500;   // SMA
			1:       return 12'o7440;   // SZA
			2:       return 12'o7420;   // SNL
			3:       return 12'o7510;   // SPA
			4:       return 12'o7450;   // SNA
			5:       return 12'o7430;   // SZL
			6:       return 12'o7410;   // SKP
			7:       return 12'o7540;   // SMA SZA
			default: return 12'o7470;   // SNA SZL
		endcase
	endfunction

	// Skip condition for case k as the mnemonic reads
	function automatic logic skip_taken(input int k, input word_t v, input logic l);
		case (k)
			0:       return v[11];
			1:       return v == '0;
			2:       return l;
			3:       return !v[11];
			4:       return v != '0;
			5:       return !l;
			6:       return 1'b1;
			7:       return v[11] || v == '0;
			default: return v != '0 && !l;      // AND group needs both
		endcase
	endfunction

	// ======================================================================
	// Bus tasks entered and left on a falling edge
	// ======================================================================
	task automatic load_word(input addr_t a, input word_t d);
		load_we   = 1'b1;
		load_addr = a;
		load_data = d;
		@(negedge clk);         // Written at the rising edge in between
		load_we   = 1'b0;
	endtask

	task automatic load_block(input addr_t base, input int n, input block_t words);
		for (int i = 0; i < n; i++)
			load_word(base + addr_t'(i), words[(n - 1 - i) * 12 +: 12]);
	endtask

	task automatic peek_word(input addr_t a, output word_t d);
		peek_addr = a;
		@(posedge clk);
		@(negedge clk);
		d = peek_data;          // Registered one cycle after the address
	endtask

	task automatic run_program(input addr_t a);
		int cycles;
		start_pc = a;
		start    = 1'b1;
		@(negedge clk);
		start    = 1'b0;
		check_bit("running after start", running, 1'b1);
		cycles = 0;
		while (running && cycles < RUN_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (running) begin
			$display("The program started at %o did not halt within %0d cycles", a, RUN_LIMIT);
			errors++;
			rst_n = 1'b0;           // Return the sequencer to IDLE
			@(negedge clk);
			rst_n = 1'b1;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors == errors_before) begin
			$display("[%0t] Test %0d %s passed", $time, tests_run, name);
		end else begin
			tests_failed++;
			$display("[%0t] Test %0d %s failed with %0d errors", $time, tests_run, name,
				errors - errors_before);
		end
		errors_before = errors;
	endtask

	// ======================================================================
	// Tests
	// ======================================================================
	task automatic idle_zero(input string when);
		check_bit({"running ", when}, running, 1'b0);
		compare_word({"AC ", when}, ac, '0);
		check_bit({"link ", when}, link, 1'b0);
		compare_word({"MQ ", when}, mq, '0);
		compare_word({"PC ", when}, pc, '0);
	endtask

	task automatic reset_state();
		rst_n = 1'b0;
		repeat (5) @(negedge clk);
		idle_zero("in reset");
		repeat (5) @(negedge clk);      // 10 cycles in all
		rst_n = 1'b1;
		@(negedge clk);
		idle_zero("after reset");
		end_test("reset state");
	endtask

	task automatic arithmetic();
		word_t       a;
		word_t       b;
		word_t       m;
		word_t       got;
		logic [12:0] v;     // Expected L,AC
		a = word_t'($urandom);
		b = word_t'($urandom);
		m = word_t'($urandom);
		// CLA CLL, TAD, TAD, AND, CMA IAC, CLL CML, RAR, RTL, RTR, RAL, RTL, DCA, HLT
		load_block(12'o0200, 13, block_t'({12'o7300, 12'o1250, 12'o1251, 12'o0252,
			12'o7041, 12'o7120, 12'o7010, 12'o7006, 12'o7012, 12'o7004, 12'o7006,
			12'o3253, 12'o7402}));
		load_word(12'o0250, a);
		load_word(12'o0251, b);
		load_word(12'o0252, m);
		run_program(12'o0200);
		v = {1'b0, a} + {1'b0, b};      // Carry out of AC sets the cleared link
		v[11:0] = v[11:0] & m;
		v[11:0] = ~v[11:0];             // CMA before IAC
		v = v + 13'd1;
		v[12] = 1'b1;                   // CLL then CML
		v = rotate13(v, -1);
		v = rotate13(v, 2);
		v = rotate13(v, -2);
		v = rotate13(v, 1);
		v = rotate13(v, 2);
		peek_word(12'o0253, got);
		compare_word("DCA result", got, v[11:0]);
		compare_word("AC after DCA", ac, '0);
		check_bit("link after rotates", link, v[12]);
		compare_word("PC after HLT", pc, 12'o0215);
		end_test("arithmetic");
	endtask

	task automatic addressing();
		word_t       x;
		word_t       y;
		word_t       z;
		word_t       got;
		logic [13:0] sum;
		x = word_t'($urandom);
		y = word_t'($urandom);
		z = word_t'($urandom);
		// TAD I current page, TAD I 0010 twice, TAD I 0410 with page bit set
		load_block(12'o0400, 6, block_t'({12'o7300, 12'o1650, 12'o1410, 12'o1410,
			12'o1610, 12'o7402}));
		load_word(12'o0010, 12'o0467);  // Bumps to 0470 before use
		load_word(12'o0410, 12'o0460);
		load_word(12'o0450, 12'o0460);
		load_word(12'o0460, x);
		load_word(12'o0470, y);
		load_word(12'o0471, z);
		run_program(12'o0400);
		sum = {2'b00, x} + {2'b00, x} + {2'b00, y} + {2'b00, z};
		compare_word("AC from indirect loads", ac, sum[11:0]);
		check_bit("link from carries", link, sum[12]);     // Each carry flips it
		peek_word(12'o0010, got);
		compare_word("auto-increment pointer", got, 12'o0471);
		peek_word(12'o0410, got);
		compare_word("current page pointer", got, 12'o0460);
		compare_word("PC after HLT", pc, 12'o0406);
		end_test("addressing");
	endtask

	task automatic control_flow();
		int    n;
		word_t got;
		n = int'($urandom % 20) + 1;
		load_block(12'o1000, 3, block_t'({12'o7300, 12'o4220, 12'o7402}));
		// Subroutine of IAC, ISZ count, JMP back and JMP I return
		load_block(12'o1020, 5, block_t'({12'o0000, 12'o7001, 12'o2250, 12'o5221,
			12'o5620}));
		load_word(12'o1050, word_t'(-n));
		run_program(12'o1000);
		compare_word("loop count in AC", ac, word_t'(n));
		check_bit("link", link, 1'b0);
		peek_word(12'o1050, got);
		compare_word("ISZ counter", got, '0);
		peek_word(12'o1020, got);
		compare_word("JMS return address", got, 12'o1002);
		compare_word("PC after HLT", pc, 12'o1003);
		end_test("control flow");
	endtask

	task automatic skip_group();
		word_t       v;
		word_t       op;
		word_t       want;
		logic        l;
		logic [31:0] rnd;
		for (int r = 0; r < 4; r++) begin
			for (int k = 0; k < 9; k++) begin
				v   = word_t'($urandom);
				rnd = $urandom;
				l   = rnd[0];
				if (r == 0)
					v = '0;
				else if (r < 3)
					v[11] = (r == 1);   // Both signs for SMA and SPA
				op = skip_op(k);
				// CLA CLL, TAD value, link setup, skip, CMA marker, HLT
				load_block(12'o1200, 6, block_t'({12'o7300, 12'o1250,
					(l ? 12'o7020 : 12'o7000), op, 12'o7040, 12'o7402}));
				load_word(12'o1250, v);
				run_program(12'o1200);
				want = skip_taken(k, v, l) ? v : ~v;
				compare_word($sformatf("AC after skip %o with AC %o L %0d", op, v, l), ac, want);
				check_bit($sformatf("link after skip %o", op), link, l);
			end
		end
		end_test("group 2 skips");
	endtask

	task automatic mq_and_switches();
		word_t d;
		word_t e;
		word_t sw;
		word_t got;
		d  = word_t'($urandom);
		e  = word_t'($urandom);
		sw = word_t'($urandom);
		switches = sw;
		// CLA OSR, MQL, TAD d, SWP, DCA, TAD e, MQA, DCA, TAD e, CAM, HLT
		load_block(12'o1400, 11, block_t'({12'o7604, 12'o7421, 12'o1250, 12'o7521,
			12'o3251, 12'o1252, 12'o7501, 12'o3253, 12'o1252, 12'o7621, 12'o7402}));
		load_word(12'o1450, d);
		load_word(12'o1452, e);
		run_program(12'o1400);
		peek_word(12'o1451, got);
		compare_word("switches through MQL and SWP", got, sw);
		peek_word(12'o1453, got);
		compare_word("MQA ORed into AC", got, d | e);
		compare_word("AC after CAM", ac, '0);
		compare_word("MQ after CAM", mq, '0);
		compare_word("PC after HLT", pc, 12'o1413);
		end_test("MQ and switches");
	endtask

	// ======================================================================
	// Sequence
	// ======================================================================
	initial begin
		clk           = 1'b0;
		rst_n         = 1'b0;
		start         = 1'b0;
		start_pc      = '0;
		switches      = '0;
		load_we       = 1'b0;
		load_addr     = '0;
		load_data     = '0;
		peek_addr     = '0;
		errors        = 0;
		errors_before = 0;
		tests_run     = 0;
		tests_failed  = 0;
		void'($urandom(18));
		reset_state();
		arithmetic();
		addressing();
		control_flow();
		skip_group();
		mq_and_switches();
		$display("Tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
